// File: src/alu_defs.svh
//----------------------------------------------------------------------------
// ALU width definitions
// Word, shift amount, leading count and divider step sizes
//----------------------------------------------------------------------------
`ifndef ALU_DEFS_SVH
`define ALU_DEFS_SVH

// Datapath word
`define ALU_WIDTH     32

// Shift amount taken from a[4:0]
`define ALU_SHAMT_W   5

`define ALU_COUNT_W   6   // Holds 0 to 32
`define ALU_DIV_STEPS 32  // One quotient bit per step

`endif

// File: src/alu_pkg.sv
//----------------------------------------------------------------------------
// ALU types
// Operation codes, divider states, request and HI/LO pair
//----------------------------------------------------------------------------
`default_nettype none

`include "alu_defs.svh"

package alu_pkg;

    // Operation select, 5 bits
    typedef enum logic [4:0] {
        ADD,    ADDU,   SUB,    SUBU,   // Arithmetic
        AND,    OR,     XOR,    NOR,    // Logic
        SLT,    SLTU,                   // Compare
        SLL,    SRL,    SRA,            // Shifts
        CLO,    CLZ,                    // Leading counts
        MFHI,   MFLO,   MTHI,   MTLO,   // HI/LO moves
        DIV,    DIVU,                   // Iterative divide
        PASS_A, PASS_B                  // Operand pass
    } alu_op_e;

    // Divider FSM
    typedef enum logic [1:0] {
        IDLE,   // Waiting for start
        RUN,    // Restore steps
        FIX     // Sign correction, result valid
    } div_state_e;

    // Request from the issue stage, 69 bits
    typedef struct packed {
        alu_op_e               op;
        logic [`ALU_WIDTH-1:0] a;
        logic [`ALU_WIDTH-1:0] b;
    } alu_req_t;

    typedef struct packed {
        logic [`ALU_WIDTH-1:0] hi;  // Remainder or MTHI
        logic [`ALU_WIDTH-1:0] lo;  // Quotient or MTLO
    } hilo_t;

endpackage

`default_nettype wire

// File: src/alu_shifter.sv
//----------------------------------------------------------------------------
// Barrel shifter for SLL, SRL and SRA
//----------------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

`include "alu_defs.svh"

module alu_shifter (
    input  wire logic [`ALU_WIDTH-1:0]   data,
    input  wire logic [`ALU_SHAMT_W-1:0] shamt,
    input  wire alu_pkg::alu_op_e        op,
    output logic [`ALU_WIDTH-1:0]        shifted
);

    logic                        left;      // SLL
    logic                        fill;      // Bit shifted in from the top
    logic [`ALU_WIDTH-1:0]       data_rev;  // data bit reversed
    logic [`ALU_WIDTH-1:0]       operand;   // Bit reversed for left shifts
    logic signed [`ALU_WIDTH:0]  ext;       // Fill bit on top of operand
    logic signed [`ALU_WIDTH:0]  ext_sh;
    logic [`ALU_WIDTH-1:0]       right;
    logic [`ALU_WIDTH-1:0]       right_rev; // Undo the reversal

    // Single right shifter, left shift done by reversing around it
    always_comb begin
        left      = (op == alu_pkg::SLL);
        fill      = (op == alu_pkg::SRA) & data[`ALU_WIDTH-1]; // Sign fill only for SRA
        data_rev  = {<<{data}};
        operand   = left ? data_rev : data;
        ext       = {fill, operand};
        ext_sh    = ext >>> shamt;            // Fill bit replicates down
        right     = ext_sh[`ALU_WIDTH-1:0];
        right_rev = {<<{right}};
        shifted   = left ? right_rev : right;
    end

endmodule

`default_nettype wire

// File: src/alu_lead_count.sv
//----------------------------------------------------------------------------
// Leading ones / leading zeros counter for CLO and CLZ
//----------------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

`include "alu_defs.svh"

module alu_lead_count (
    input  wire logic [`ALU_WIDTH-1:0] value,
    input  wire logic                  count_ones,  // 1 for CLO, 0 for CLZ
    output logic [`ALU_COUNT_W-1:0]    count
);

    logic found;    // First differing bit seen

    //------------------------------------------------------------------------
    // Priority scan from the MSB down
    //------------------------------------------------------------------------
    always_comb begin
        count = `ALU_COUNT_W'(`ALU_WIDTH);  // Uniform word
        found = 1'b0;
        for (int i = `ALU_WIDTH - 1; i >= 0; i--) begin
            if (!found && (value[i] != count_ones)) begin
                count = `ALU_COUNT_W'(`ALU_WIDTH - 1 - i);
                found = 1'b1;   // Lock the highest hit
            end
        end
    end

endmodule

`default_nettype wire

// File: src/alu_int_unit.sv
//----------------------------------------------------------------------------
// Integer datapath
// Add/sub, logic, compare, shift, counts and the result multiplexer
//----------------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

`include "alu_defs.svh"

module alu_int_unit (
    input  wire alu_pkg::alu_req_t req,
    input  wire alu_pkg::hilo_t    hilo,
    output logic [`ALU_WIDTH-1:0]  result,
    output logic                   overflow
);

    logic [`ALU_WIDTH-1:0]  sum_diff;   // a+b or a-b
    logic                   is_add;
    logic [`ALU_WIDTH-1:0]  shift_res;
    logic [`ALU_COUNT_W-1:0] lead_cnt;
    logic                   a_msb;
    logic                   b_msb;

    assign is_add   = (req.op == alu_pkg::ADD) | (req.op == alu_pkg::ADDU);
    assign sum_diff = is_add ? (req.a + req.b) : (req.a - req.b);
    assign a_msb    = req.a[`ALU_WIDTH-1];
    assign b_msb    = req.b[`ALU_WIDTH-1];

    // Shift b by a[4:0], MIPS operand order
    alu_shifter u_shifter (
        .data    (req.b),
        .shamt   (req.a[`ALU_SHAMT_W-1:0]),
        .op      (req.op),
        .shifted (shift_res)
    );

    alu_lead_count u_lead_count (
        .value      (req.a),
        .count_ones (req.op == alu_pkg::CLO),
        .count      (lead_cnt)
    );

    //------------------------------------------------------------------------
    // Signed overflow, ADD and SUB only
    //------------------------------------------------------------------------
    always_comb begin
        case (req.op)
            alu_pkg::ADD: overflow = (a_msb ~^ b_msb) & (a_msb ^ sum_diff[`ALU_WIDTH-1]);
            alu_pkg::SUB: overflow = (a_msb ^ b_msb) & (a_msb ^ sum_diff[`ALU_WIDTH-1]);
            default:      overflow = 1'b0;
        endcase
    end

    //------------------------------------------------------------------------
    // Result multiplexer
    //------------------------------------------------------------------------
    always_comb begin
        case (req.op)
            alu_pkg::ADD,
            alu_pkg::ADDU,
            alu_pkg::SUB,
            alu_pkg::SUBU:   result = sum_diff;
            alu_pkg::AND:    result = req.a & req.b;
            alu_pkg::OR:     result = req.a | req.b;
            alu_pkg::XOR:    result = req.a ^ req.b;
            alu_pkg::NOR:    result = ~(req.a | req.b);
            alu_pkg::SLT:    result = `ALU_WIDTH'($signed(req.a) < $signed(req.b));
            alu_pkg::SLTU:   result = `ALU_WIDTH'(req.a < req.b);
            alu_pkg::SLL,
            alu_pkg::SRL,
            alu_pkg::SRA:    result = shift_res;
            alu_pkg::CLO,
            alu_pkg::CLZ:    result = `ALU_WIDTH'(lead_cnt);  // Zero extended
            alu_pkg::MFHI:   result = hilo.hi;
            alu_pkg::MFLO:   result = hilo.lo;
            alu_pkg::PASS_A: result = req.a;
            alu_pkg::PASS_B: result = req.b;
            default:         result = '0;   // MTHI, MTLO, DIV, DIVU
        endcase
    end

endmodule

`default_nettype wire

// File: src/alu_divider.sv
//----------------------------------------------------------------------------
// Radix-2 restoring divider, signed or unsigned
// One quotient bit per cycle, sign fixed up on the way out
//----------------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

`include "alu_defs.svh"

module alu_divider (
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire logic                  start,
    input  wire logic                  signed_op,
    input  wire logic [`ALU_WIDTH-1:0] dividend,
    input  wire logic [`ALU_WIDTH-1:0] divisor,
    output logic                       busy,
    output logic [`ALU_WIDTH-1:0]      quotient,
    output logic [`ALU_WIDTH-1:0]      remainder
);

    alu_pkg::div_state_e  state;
    logic [5:0]           step_cnt;   // 0 .. ALU_DIV_STEPS-1

    logic [`ALU_WIDTH-1:0] quo;       // Dividend shifts out, quotient shifts in
    logic [`ALU_WIDTH-1:0] rem;       // Partial remainder
    logic [`ALU_WIDTH-1:0] dvs;       // Divisor magnitude
    logic                  neg_q;     // Quotient sign
    logic                  neg_r;     // Remainder follows dividend

    logic [`ALU_WIDTH-1:0] dividend_mag;
    logic [`ALU_WIDTH-1:0] divisor_mag;
    logic [`ALU_WIDTH:0]   trial;     // Shifted remainder
    logic [`ALU_WIDTH:0]   diff;      // Trial minus divisor

    assign dividend_mag = (signed_op & dividend[`ALU_WIDTH-1]) ? -dividend : dividend;
    assign divisor_mag  = (signed_op & divisor[`ALU_WIDTH-1])  ? -divisor  : divisor;

    // Bring down next dividend bit
    assign trial = {rem, quo[`ALU_WIDTH-1]};
    assign diff  = trial - {1'b0, dvs};

    //------------------------------------------------------------------------
    // Control FSM
    //------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= alu_pkg::IDLE;
            step_cnt <= '0;
        end else begin
            case (state)
                alu_pkg::IDLE: begin
                    step_cnt <= '0;
                    if (start)
                        state <= alu_pkg::RUN;
                end
                alu_pkg::RUN: begin
                    step_cnt <= step_cnt + 6'd1;
                    if (step_cnt == 6'(`ALU_DIV_STEPS - 1))
                        state <= alu_pkg::FIX;  // Last bit done
                end
                default: state <= alu_pkg::IDLE; // FIX lasts one cycle
            endcase
        end
    end

    // Datapath, no reset on payload
    always_ff @(posedge clk) begin
        if (state == alu_pkg::IDLE && start) begin
            quo   <= dividend_mag;
            rem   <= '0;
            dvs   <= divisor_mag;
            neg_q <= signed_op & (dividend[`ALU_WIDTH-1] ^ divisor[`ALU_WIDTH-1]);
            neg_r <= signed_op & dividend[`ALU_WIDTH-1];
        end else if (state == alu_pkg::RUN) begin
            if (!diff[`ALU_WIDTH]) begin        // Fits, keep difference
                rem <= diff[`ALU_WIDTH-1:0];
                quo <= {quo[`ALU_WIDTH-2:0], 1'b1};
            end else begin                      // Restore
                rem <= trial[`ALU_WIDTH-1:0];
                quo <= {quo[`ALU_WIDTH-2:0], 1'b0};
            end
        end
    end

    assign busy = (state == alu_pkg::RUN);

    // Sign correction, taken by HI/LO in the FIX cycle
    assign quotient  = neg_q ? -quo : quo;   // Truncates toward zero
    assign remainder = neg_r ? -rem : rem;

endmodule

`default_nettype wire

// File: src/alu_hilo_unit.sv
//----------------------------------------------------------------------------
// HI/LO register with divide start control and stall request
//----------------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

`include "alu_defs.svh"

module alu_hilo_unit (
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire alu_pkg::alu_req_t req,
    input  wire logic              stall,
    input  wire logic              flush,
    output alu_pkg::hilo_t         hilo,
    output logic                   request_stall
);

    logic                  accept;      // Request counts this cycle
    logic                  div_start;
    logic                  div_active;  // Start seen, result not yet written
    logic                  div_busy;
    logic                  div_done;    // FIX cycle
    logic [`ALU_WIDTH-1:0] quotient;
    logic [`ALU_WIDTH-1:0] remainder;

    assign accept = ~(stall | flush);

    // One pulse, skipped for b == 0 and while a divide is in flight
    assign div_start = ((req.op == alu_pkg::DIV) | (req.op == alu_pkg::DIVU))
                     & (req.b != '0) & ~div_active & accept;

    assign div_done      = div_active & ~div_busy;
    assign request_stall = div_start | div_busy;

    alu_divider u_div (
        .clk       (clk),
        .rst       (rst),
        .start     (div_start),
        .signed_op (req.op == alu_pkg::DIV),
        .dividend  (req.a),
        .divisor   (req.b),
        .busy      (div_busy),
        .quotient  (quotient),
        .remainder (remainder)
    );

    always_ff @(posedge clk) begin
        if (rst)
            div_active <= 1'b0;
        else if (div_start)
            div_active <= 1'b1;
        else if (div_done)
            div_active <= 1'b0;     // Free again after FIX
    end

    //------------------------------------------------------------------------
    // HI/LO write, divider first
    //------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            hilo <= '0;
        end else if (div_done) begin
            hilo.hi <= remainder;
            hilo.lo <= quotient;
        end else if (accept) begin
            if (req.op == alu_pkg::MTHI)
                hilo.hi <= req.a;
            else if (req.op == alu_pkg::MTLO)
                hilo.lo <= req.a;
        end
    end

endmodule

`default_nettype wire

// File: src/alu_core.sv
//----------------------------------------------------------------------------
// Execution unit top, integer datapath plus HI/LO and divider
//----------------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

`include "alu_defs.svh"

module alu_core (
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire alu_pkg::alu_req_t req,
    input  wire logic              stall,         // Held by a later stage
    input  wire logic              flush,         // Stage cancelled
    output logic [`ALU_WIDTH-1:0]  result,
    output logic                   overflow,
    output logic                   request_stall  // Divide in progress
);

    alu_pkg::hilo_t hilo;   // Current HI/LO for MFHI/MFLO

    alu_int_unit u_int (
        .req      (req),
        .hilo     (hilo),
        .result   (result),
        .overflow (overflow)
    );

    alu_hilo_unit u_hilo (
        .clk           (clk),
        .rst           (rst),
        .req           (req),
        .stall         (stall),
        .flush         (flush),
        .hilo          (hilo),
        .request_stall (request_stall)
    );

endmodule

`default_nettype wire

// File: test/alu_core_chk.sv
//----------------------------------------------------------------------------
// Bound checker for the execution unit
// Stall and overflow rules as concurrent assertions
//----------------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module alu_core_chk (
    input wire logic                clk,
    input wire logic                rst,
    input wire alu_pkg::alu_req_t   req,
    input wire logic                overflow,
    input wire logic                request_stall,
    input wire alu_pkg::div_state_e div_state    // Divider FSM state
);

    int unsigned assert_errors = 0;  // Failed assertion count, read by the testbench

    // Divider must come out of reset idle
    stall_after_reset: assert property (@(posedge clk) rst |=> !request_stall)
        else begin
            assert_errors++;
            $error("request_stall high in the cycle after reset");
        end

    stall_in_run: assert property (@(posedge clk) disable iff (rst)
        (div_state == alu_pkg::RUN) |-> request_stall)
        else begin
            assert_errors++;
            $error("request_stall low while the divider runs");
        end

    // Only the trapping add and subtract flag overflow
    overflow_ops: assert property (@(posedge clk) disable iff (rst)
        overflow |-> (req.op == alu_pkg::ADD || req.op == alu_pkg::SUB))
        else begin
            assert_errors++;
            $error("overflow high for an operation other than ADD or SUB");
        end

endmodule

bind alu_core alu_core_chk chk0 (
    .clk           (clk),
    .rst           (rst),
    .req           (req),
    .overflow      (overflow),
    .request_stall (request_stall),
    .div_state     (u_hilo.u_div.state)
);

`default_nettype wire

// File: test/alu_core_tb.sv
//----------------------------------------------------------------------------
// Testbench for the execution unit
// Random and directed ops against a reference model, HI/LO and divides
//----------------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

`include "alu_defs.svh"

module alu_core_tb;

    localparam int CLK_PERIOD  = 20;
    localparam int DIV_TIMEOUT = 100;              // Cycles per divide wait
    localparam int MSB         = `ALU_WIDTH - 1;

    typedef struct packed {
        logic [`ALU_WIDTH-1:0] result;
        logic                  overflow;
    } expect_t;

    logic                  clk;
    logic                  rst;
    alu_pkg::alu_req_t     req;
    logic                  stall;
    logic                  flush;
    logic [`ALU_WIDTH-1:0] result;
    logic                  overflow;
    logic                  request_stall;

    alu_pkg::hilo_t        model_hilo;             // Expected HI/LO
    expect_t               expected;
    string                 test_name;              // Current test
    string                 check_name;             // Test of the request on the bus
    alu_pkg::alu_op_e      arith_ops [12];

    alu_core dut0 (
        .clk           (clk),
        .rst           (rst),
        .req           (req),
        .stall         (stall),
        .flush         (flush),
        .result        (result),
        .overflow      (overflow),
        .request_stall (request_stall)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    //------------------------------------------------------------------------
    // Reference model
    //------------------------------------------------------------------------
    function automatic expect_t ref_result(alu_pkg::alu_req_t r, alu_pkg::hilo_t h);
        expect_t               e;
        logic [`ALU_WIDTH-1:0] s;
        logic                  ones;
        e    = '0;
        s    = (r.op == alu_pkg::ADD || r.op == alu_pkg::ADDU) ? r.a + r.b : r.a - r.b;
        ones = (r.op == alu_pkg::CLO);
        case (r.op)
            alu_pkg::ADD: begin
                e.result   = s;
                e.overflow = (r.a[MSB] == r.b[MSB]) && (s[MSB] != r.a[MSB]);
            end
            alu_pkg::SUB: begin
                e.result   = s;
                e.overflow = (r.a[MSB] != r.b[MSB]) && (s[MSB] != r.a[MSB]);
            end
            alu_pkg::ADDU, alu_pkg::SUBU: e.result = s;
            alu_pkg::AND:    e.result = r.a & r.b;
            alu_pkg::OR:     e.result = r.a | r.b;
            alu_pkg::XOR:    e.result = r.a ^ r.b;
            alu_pkg::NOR:    e.result = ~(r.a | r.b);
            alu_pkg::SLT:    e.result = ($signed(r.a) < $signed(r.b)) ? 1 : 0;
            alu_pkg::SLTU:   e.result = (r.a < r.b) ? 1 : 0;
            alu_pkg::SLL:    e.result = r.b << r.a[`ALU_SHAMT_W-1:0];
            alu_pkg::SRL:    e.result = r.b >> r.a[`ALU_SHAMT_W-1:0];
            alu_pkg::SRA:    e.result = $signed(r.b) >>> r.a[`ALU_SHAMT_W-1:0];
            alu_pkg::CLO, alu_pkg::CLZ: begin
                for (int i = MSB; i >= 0 && r.a[i] == ones; i--)
                    e.result = e.result + 1;     // Run of leading matches
            end
            alu_pkg::MFHI:   e.result = h.hi;
            alu_pkg::MFLO:   e.result = h.lo;
            alu_pkg::PASS_A: e.result = r.a;
            alu_pkg::PASS_B: e.result = r.b;
            default:         e.result = '0;      // Moves to HI/LO and divides
        endcase
        return e;
    endfunction

    // Truncating divide, remainder follows the dividend sign
    function automatic alu_pkg::hilo_t div_ref(logic is_signed, logic [`ALU_WIDTH-1:0] a,
                                               logic [`ALU_WIDTH-1:0] b);
        alu_pkg::hilo_t        h;
        logic [`ALU_WIDTH-1:0] a_mag;
        logic [`ALU_WIDTH-1:0] b_mag;
        logic                  neg_a;
        logic                  neg_b;
        neg_a = is_signed & a[MSB];
        neg_b = is_signed & b[MSB];
        a_mag = neg_a ? (~a + 1) : a;
        b_mag = neg_b ? (~b + 1) : b;
        h.lo  = (neg_a ^ neg_b) ? -(a_mag / b_mag) : (a_mag / b_mag);
        h.hi  = neg_a ? -(a_mag % b_mag) : (a_mag % b_mag);
        return h;
    endfunction

    //------------------------------------------------------------------------
    // Failure and compare tasks
    //------------------------------------------------------------------------
    task automatic abort_run();
        $display("Checks failed");
        $fatal(1, "Simulation stopped at the first failure");
    endtask

    task automatic check_word(string name, logic [`ALU_WIDTH-1:0] exp_val,
                              logic [`ALU_WIDTH-1:0] act_val);
        if (act_val !== exp_val) begin
            $display("Error %s: expected %h, actual %h", name, exp_val, act_val);
            abort_run();
        end
    endtask

    task automatic check_flag(string name, logic exp_val, logic act_val);
        if (act_val !== exp_val) begin
            $display("Error %s: expected %b, actual %b", name, exp_val, act_val);
            abort_run();
        end
    endtask

    task automatic check_hilo(string name, alu_pkg::hilo_t exp_val, alu_pkg::hilo_t act_val);
        if (act_val !== exp_val) begin
            $display("Error %s: expected hi %h lo %h, actual hi %h lo %h", name,
                     exp_val.hi, exp_val.lo, act_val.hi, act_val.lo);
            abort_run();
        end
    endtask

    // Per-cycle compare, 1 ns before the next edge
    always @(posedge clk) begin
        #(CLK_PERIOD - 1);
        if (!rst) begin
            expected = ref_result(req, model_hilo);
            check_word({check_name, " result"}, expected.result, result);
            check_flag({check_name, " overflow"}, expected.overflow, overflow);
            if (dut0.chk0.assert_errors != 0) begin
                $display("A bound assertion failed during %s", check_name);
                abort_run();
            end
            if (!stall && !flush) begin                      // Accepted cycle
                if (req.op == alu_pkg::MTHI)
                    model_hilo.hi = req.a;
                else if (req.op == alu_pkg::MTLO)
                    model_hilo.lo = req.a;
            end
        end
    end

    //------------------------------------------------------------------------
    // Stimulus tasks
    //------------------------------------------------------------------------
    task automatic drive_req(alu_pkg::alu_op_e op, logic [`ALU_WIDTH-1:0] a,
                             logic [`ALU_WIDTH-1:0] b, logic st = 1'b0, logic fl = 1'b0);
        @(posedge clk);
        #2;
        req.op     = op;
        req.a      = a;
        req.b      = b;
        stall      = st;
        flush      = fl;
        check_name = test_name;
    endtask

    // MFHI then MFLO, compared as a pair with the model
    task automatic read_hilo(string name);
        alu_pkg::hilo_t got;
        test_name = name;
        drive_req(alu_pkg::MFHI, $urandom, $urandom);
        #(CLK_PERIOD - 4);
        got.hi = result;
        drive_req(alu_pkg::MFLO, $urandom, $urandom);
        #(CLK_PERIOD - 4);
        got.lo = result;
        check_hilo({name, " hilo"}, model_hilo, got);
    endtask

    task automatic run_div(string name, alu_pkg::alu_op_e op, logic [`ALU_WIDTH-1:0] a,
                           logic [`ALU_WIDTH-1:0] b);
        int   cycles;
        logic done;
        test_name = name;
        cycles    = 0;
        done      = (b == '0);                 // No start for a zero divisor
        drive_req(op, a, b);                   // Held until request_stall drops
        #(CLK_PERIOD - 4);
        check_flag({name, " start stall"}, (b != '0), request_stall);
        while (!done) begin
            @(posedge clk);
            #(CLK_PERIOD - 2);
            cycles++;
            if (!request_stall) begin
                done = 1'b1;                   // FIX cycle
            end else if (cycles > DIV_TIMEOUT) begin
                $display("Timeout: request_stall did not fall during %s", name);
                abort_run();
            end
        end
        if (b != '0) begin
            check_word({name, " latency"}, `ALU_WIDTH'(`ALU_DIV_STEPS + 1), `ALU_WIDTH'(cycles));
            model_hilo = div_ref(op == alu_pkg::DIV, a, b);
        end
        read_hilo(name);
    endtask

    //------------------------------------------------------------------------
    // Test sequence
    //------------------------------------------------------------------------
    initial begin
        logic [`ALU_WIDTH-1:0] div_b;
        clk        = 1'b0;
        rst        = 1'b1;
        stall      = 1'b0;
        flush      = 1'b0;
        req.op     = alu_pkg::PASS_A;
        req.a      = '0;
        req.b      = '0;
        model_hilo = '0;
        test_name  = "reset";
        check_name = "reset";
        arith_ops  = '{alu_pkg::ADD, alu_pkg::ADDU, alu_pkg::SUB, alu_pkg::SUBU, alu_pkg::AND,
                       alu_pkg::OR, alu_pkg::XOR, alu_pkg::NOR, alu_pkg::SLT, alu_pkg::SLTU,
                       alu_pkg::PASS_A, alu_pkg::PASS_B};
        void'($urandom(32'hb03de308));
        repeat (3) @(posedge clk);
        #2;
        rst = 1'b0;
        read_hilo("reset_hilo");               // Cleared by reset

        test_name = "arith_random";
        repeat (30) begin
            foreach (arith_ops[i]) begin
                drive_req(arith_ops[i], $urandom, $urandom);
            end
        end
        test_name = "overflow_corners";
        drive_req(alu_pkg::ADD,  32'h7fffffff, 32'h00000001);
        drive_req(alu_pkg::ADD,  32'h80000000, 32'h80000000);
        drive_req(alu_pkg::ADD,  32'h7fffffff, 32'h80000000);  // Mixed signs
        drive_req(alu_pkg::ADDU, 32'h7fffffff, 32'h00000001);
        drive_req(alu_pkg::SUB,  32'h80000000, 32'h00000001);
        drive_req(alu_pkg::SUB,  32'h7fffffff, 32'hffffffff);
        drive_req(alu_pkg::SUBU, 32'h80000000, 32'h00000001);
        drive_req(alu_pkg::SLT,  32'h80000000, 32'h7fffffff);
        drive_req(alu_pkg::SLTU, 32'h80000000, 32'h7fffffff);

        test_name = "shifts";
        for (int amt = 0; amt < 32; amt++) begin   // Upper bits of a ignored
            drive_req(alu_pkg::SLL, ($urandom & 32'hffffffe0) | amt, $urandom);
            drive_req(alu_pkg::SRL, ($urandom & 32'hffffffe0) | amt, $urandom);
            drive_req(alu_pkg::SRA, ($urandom & 32'hffffffe0) | amt, $urandom);
            drive_req(alu_pkg::SRA, amt, $urandom | 32'h80000000);
        end

        test_name = "counts";
        drive_req(alu_pkg::CLO, '0, '0);
        drive_req(alu_pkg::CLZ, '0, '0);
        drive_req(alu_pkg::CLO, '1, '0);
        drive_req(alu_pkg::CLZ, '1, '0);
        for (int i = 0; i < 32; i++) begin
            drive_req(alu_pkg::CLZ, 32'h1 << i, '0);
            drive_req(alu_pkg::CLO, 32'h1 << i, '0);
            drive_req(alu_pkg::CLO, ~(32'h1 << i), '0);
        end
        repeat (20) begin
            drive_req(alu_pkg::CLZ, $urandom >> ($urandom % 32), '0);
            drive_req(alu_pkg::CLO, ~($urandom >> ($urandom % 32)), '0);
        end

        test_name = "hilo_moves";
        drive_req(alu_pkg::MTHI, 32'h12345678, $urandom);
        drive_req(alu_pkg::MTLO, 32'h9abcdef0, $urandom);
        read_hilo("hilo_moves");
        test_name = "hilo_blocked";
        drive_req(alu_pkg::MTHI, $urandom, $urandom, 1'b1, 1'b0);  // Stalled
        drive_req(alu_pkg::MTLO, $urandom, $urandom, 1'b1, 1'b0);
        drive_req(alu_pkg::MTHI, $urandom, $urandom, 1'b0, 1'b1);  // Flushed
        drive_req(alu_pkg::MTLO, $urandom, $urandom, 1'b0, 1'b1);
        read_hilo("hilo_blocked");

        run_div("div_pos",          alu_pkg::DIV,  32'd100,      32'd7);
        run_div("div_neg_dividend", alu_pkg::DIV,  32'hffffff9c, 32'd7);
        run_div("div_neg_divisor",  alu_pkg::DIV,  32'd100,      32'hfffffff9);
        run_div("div_both_neg",     alu_pkg::DIV,  32'hffffff9c, 32'hfffffff9);
        run_div("div_min_pos",      alu_pkg::DIV,  32'h80000000, 32'd7);
        run_div("div_min_neg",      alu_pkg::DIV,  32'h80000000, 32'hfffffffd);
        run_div("div_min_by_m1",    alu_pkg::DIV,  32'h80000000, 32'hffffffff);
        run_div("divu_max",         alu_pkg::DIVU, 32'hffffffff, 32'd3);
        run_div("divu_big",         alu_pkg::DIVU, 32'h80000000, 32'hffffffff);
        repeat (8) begin
            div_b = ($urandom >> ($urandom % 32)) | 32'h1;     // Never zero
            run_div("div_random", alu_pkg::DIV, $urandom, div_b);
            div_b = ($urandom >> ($urandom % 32)) | 32'h1;
            run_div("divu_random", alu_pkg::DIVU, $urandom, div_b);
        end

        test_name = "div_by_zero";
        drive_req(alu_pkg::MTHI, 32'h13579bdf, '0);
        drive_req(alu_pkg::MTLO, 32'h2468ace0, '0);
        run_div("divu_by_zero", alu_pkg::DIVU, $urandom, '0);
        run_div("div_by_zero",  alu_pkg::DIV,  $urandom, '0);

        #(CLK_PERIOD);                          // Let the last compare run
        if (dut0.chk0.assert_errors != 0) begin
            $display("A bound assertion failed");
            abort_run();
        end else begin
            $display("All checks passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: alu_core.f
+incdir+src
src/alu_pkg.sv
src/alu_shifter.sv
src/alu_lead_count.sv
src/alu_int_unit.sv
src/alu_divider.sv
src/alu_hilo_unit.sv
src/alu_core.sv
test/alu_core_chk.sv
test/alu_core_tb.sv
